// File: logic/crc_pkg.sv
package crc_pkg;

	typedef logic [31:0] word_t;
	typedef logic [7:0] idr_t;
	typedef logic [2:0] reg_addr_t; // word offset within the peripheral

	localparam reg_addr_t ADDR_DR = 3'd0;
	localparam reg_addr_t ADDR_IDR = 3'd1;
	localparam reg_addr_t ADDR_CR = 3'd2;
	localparam reg_addr_t ADDR_INIT = 3'd4;
	localparam reg_addr_t ADDR_POL = 3'd5;

	localparam word_t POLY_RESET = 32'h04C1_1DB7;
	localparam word_t INIT_RESET = 32'hFFFF_FFFF;

	localparam int BUF_DEPTH = 2;
	localparam int BUF_PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int BUF_CNT_W = $clog2(BUF_DEPTH + 1);

	localparam logic RESP_OKAY = 1'b0;
	localparam logic RESP_ERROR = 1'b1;

	typedef enum logic [1:0] {
		SIZE_8 = 2'b00,
		SIZE_16 = 2'b01,
		SIZE_32 = 2'b10
	} xfer_size_t;

	typedef enum logic [1:0] {
		POLY_32 = 2'b00,
		POLY_16 = 2'b01,
		POLY_8 = 2'b10,
		POLY_7 = 2'b11
	} poly_size_t;

	typedef enum logic [1:0] {
		REV_NONE = 2'b00,
		REV_BYTE = 2'b01,
		REV_HALF = 2'b10,
		REV_WORD = 2'b11
	} rev_in_t;

	typedef enum logic [1:0] {
		HTRANS_IDLE = 2'b00,
		HTRANS_BUSY = 2'b01,
		HTRANS_NONSEQ = 2'b10,
		HTRANS_SEQ = 2'b11
	} htrans_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SHIFT,
		ST_RELOAD
	} engine_state_t;

endpackage

// File: logic/crc_buf_if.sv
`timescale 1ns/1ps

interface crc_buf_if;
	import crc_pkg::*;

	word_t word;
	xfer_size_t size;
	logic valid;
	logic pop; // head entry leaves at the edge where this is high

	modport buffer
	(
		output word, size, valid,
		input pop
	);

	modport engine
	(
		input word, size, valid,
		output pop
	);

endinterface

// File: logic/crc_host_if.sv
`timescale 1ns/1ps

module crc_host_if
(
	input logic HCLK,
	input logic HRESETn,
	input logic HSEL,
	input logic [31:0] HADDR,
	input crc_pkg::htrans_t HTRANS,
	input logic HWRITE,
	input logic [2:0] HSIZE,
	input logic HREADY,
	input crc_pkg::word_t HWDATA,
	output crc_pkg::word_t HRDATA,
	output logic HREADYOUT,
	output logic HRESP,
	output crc_pkg::word_t bus_wr,
	output crc_pkg::xfer_size_t bus_size,
	output logic buffer_write_en,
	output logic crc_init_en,
	output logic crc_poly_en,
	output logic crc_idr_en,
	output logic reset_chain,
	output crc_pkg::poly_size_t poly_size,
	output crc_pkg::rev_in_t rev_in,
	output logic rev_out,
	input logic buffer_full,
	input logic read_wait,
	input logic reset_pending,
	input crc_pkg::word_t crc_out,
	input crc_pkg::word_t crc_init_out,
	input crc_pkg::word_t crc_poly_out,
	input crc_pkg::idr_t crc_idr_out
);
	import crc_pkg::*;

	reg_addr_t addr_q;
	xfer_size_t size_q;
	logic write_q;
	logic sel_q;
	poly_size_t poly_size_q;
	rev_in_t rev_in_q;
	logic rev_out_q;
	logic sample;
	logic wr_active;
	logic rd_active;
	logic dr_wr;
	logic dr_rd;
	logic init_wr;
	logic cr_wr;

	assign sample = HREADY && HREADYOUT; // address phase completes

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			sel_q <= 1'b0;
		else if (sample)
			sel_q <= HSEL && (HTRANS == HTRANS_NONSEQ); // seq and busy are ignored
	end

	always_ff @(posedge HCLK)
	begin
		if (sample)
		begin
			addr_q <= HADDR[4:2];
			size_q <= xfer_size_t'(HSIZE[1:0]);
			write_q <= HWRITE;
		end
	end

	assign wr_active = sel_q && write_q;
	assign rd_active = sel_q && !write_q;
	assign dr_wr = wr_active && (addr_q == ADDR_DR);
	assign dr_rd = rd_active && (addr_q == ADDR_DR);
	assign init_wr = wr_active && (addr_q == ADDR_INIT);
	assign cr_wr = wr_active && (addr_q == ADDR_CR);

	assign buffer_write_en = dr_wr && !buffer_full;
	assign crc_init_en = init_wr && !reset_pending;
	assign crc_poly_en = wr_active && (addr_q == ADDR_POL);
	assign crc_idr_en = wr_active && (addr_q == ADDR_IDR);

	// each stall lasts only as long as its own condition
	assign HREADYOUT = !((dr_wr && buffer_full) ||
		(dr_rd && read_wait) ||
		(init_wr && reset_pending));
	assign HRESP = RESP_OKAY;
	assign bus_wr = HWDATA;
	assign bus_size = size_q;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			poly_size_q <= POLY_32;
			rev_in_q <= REV_NONE;
			rev_out_q <= 1'b0;
		end
		else if (cr_wr)
		begin
			poly_size_q <= poly_size_t'(HWDATA[4:3]);
			rev_in_q <= rev_in_t'(HWDATA[6:5]);
			rev_out_q <= HWDATA[7];
		end
	end

	assign reset_chain = cr_wr && HWDATA[0]; // the bit itself is not stored
	assign poly_size = poly_size_q;
	assign rev_in = rev_in_q;
	assign rev_out = rev_out_q;

	always_comb
	begin
		case (addr_q)
			ADDR_DR: HRDATA = crc_out;
			ADDR_IDR: HRDATA = {24'h0, crc_idr_out};
			ADDR_CR: HRDATA = {24'h0, rev_out_q, rev_in_q, poly_size_q, 3'b000};
			ADDR_INIT: HRDATA = crc_init_out;
			ADDR_POL: HRDATA = crc_poly_out;
			default: HRDATA = '0;
		endcase
	end

	a_resp_okay: assert property (@(posedge HCLK) disable iff (!HRESETn)
		HRESP != RESP_ERROR);

endmodule

// File: logic/crc_data_buffer.sv
`timescale 1ns/1ps

module crc_data_buffer
(
	input logic HCLK,
	input logic HRESETn,
	input logic push,
	input crc_pkg::word_t push_word,
	input crc_pkg::xfer_size_t push_size,
	input logic flush,
	output logic full,
	crc_buf_if.buffer deq
);
	import crc_pkg::*;

	word_t word_mem [BUF_DEPTH];
	xfer_size_t size_mem [BUF_DEPTH];
	logic [BUF_PTR_W-1:0] wr_ptr;
	logic [BUF_PTR_W-1:0] rd_ptr;
	logic [BUF_CNT_W-1:0] count;

	function automatic logic [BUF_PTR_W-1:0] next_ptr(input logic [BUF_PTR_W-1:0] p);
		return (p == BUF_PTR_W'(BUF_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn || flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (deq.pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, deq.pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (push && !flush)
		begin
			word_mem[wr_ptr] <= push_word;
			size_mem[wr_ptr] <= push_size;
		end
	end

	assign full = (count == BUF_CNT_W'(BUF_DEPTH));
	assign deq.valid = (count != '0);
	assign deq.word = word_mem[rd_ptr];
	assign deq.size = size_mem[rd_ptr];

	// the host holds a DR write in its data phase while the buffer is full
	a_no_overflow: assert property (@(posedge HCLK) disable iff (!HRESETn)
		push && full |-> flush);

endmodule

// File: logic/crc_engine.sv
`timescale 1ns/1ps

module crc_engine
(
	input logic HCLK,
	input logic HRESETn,
	crc_buf_if.engine deq,
	input logic reset_chain,
	input crc_pkg::poly_size_t poly_size,
	input crc_pkg::rev_in_t rev_in,
	input logic rev_out,
	input crc_pkg::word_t init_value,
	input crc_pkg::word_t poly,
	output crc_pkg::word_t crc_out,
	output logic read_wait,
	output logic reset_pending
);
	import crc_pkg::*;

	engine_state_t state;
	word_t crc_q;
	word_t shift_q; // next byte to process sits in the top lane
	logic [1:0] bytes_left;
	logic [5:0] width;
	word_t width_mask;
	logic [4:0] rev_mask;
	word_t rev_word;
	word_t load_word;
	logic [1:0] load_left;
	logic last_byte;
	word_t crc_step;

	// bit i takes bit i ^ mask, mirroring every aligned group of mask + 1 bits
	function automatic word_t mirror(input word_t w, input logic [4:0] mask);
		word_t r;
		for (int i = 0; i < 32; i++)
			r[i] = w[5'(i) ^ mask];
		return r;
	endfunction

	function automatic word_t reflect_width(input word_t w, input logic [5:0] n);
		word_t r;
		r = '0;
		for (int i = 0; i < 32; i++)
			if (i < n)
				r[i] = w[n - 1 - i];
		return r;
	endfunction

	function automatic word_t crc_byte
	(
		input word_t c,
		input logic [7:0] d,
		input word_t p,
		input word_t m,
		input logic [5:0] n
	);
		word_t r;
		logic fb;
		r = c & m;
		for (int j = 7; j >= 0; j--)
		begin
			fb = r[n - 1] ^ d[j]; // msb first, no reflection
			r = (r << 1) & m;
			if (fb)
				r = r ^ (p & m);
		end
		return r;
	endfunction

	always_comb
	begin
		case (poly_size)
			POLY_16: width = 6'd16;
			POLY_8: width = 6'd8;
			POLY_7: width = 6'd7;
			default: width = 6'd32;
		endcase
	end

	assign width_mask = 32'hFFFF_FFFF >> (6'd32 - width);

	always_comb
	begin
		case (rev_in)
			REV_BYTE: rev_mask = 5'd7;
			REV_HALF: rev_mask = 5'd15;
			REV_WORD: rev_mask = 5'd31;
			default: rev_mask = 5'd0;
		endcase
		// reversal never spans past the transfer so the data stays in the low lanes
		case (deq.size)
			SIZE_8: rev_mask = rev_mask & 5'd7;
			SIZE_16: rev_mask = rev_mask & 5'd15;
			default: rev_mask = rev_mask;
		endcase
	end

	assign rev_word = mirror(deq.word, rev_mask);

	always_comb
	begin
		case (deq.size)
			SIZE_8:
			begin
				load_word = rev_word << 24;
				load_left = 2'd0;
			end
			SIZE_16:
			begin
				load_word = rev_word << 16;
				load_left = 2'd1;
			end
			default:
			begin
				load_word = rev_word;
				load_left = 2'd3;
			end
		endcase
	end

	assign last_byte = (state == ST_SHIFT) && (bytes_left == 2'd0);
	assign deq.pop = deq.valid && !reset_chain && ((state == ST_IDLE) || last_byte);
	assign crc_step = crc_byte(crc_q, shift_q[31:24], poly, width_mask, width);

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state <= ST_IDLE;
			crc_q <= INIT_RESET;
			bytes_left <= 2'd0;
		end
		else if (reset_chain)
			state <= ST_RELOAD; // a word in flight is dropped
		else
		begin
			case (state)
				ST_RELOAD:
				begin
					crc_q <= init_value;
					state <= ST_IDLE;
				end
				ST_SHIFT:
				begin
					crc_q <= crc_step;
					bytes_left <= bytes_left - 2'd1;
					if (last_byte)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
			if (deq.pop)
			begin
				state <= ST_SHIFT;
				bytes_left <= load_left;
			end
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (deq.pop)
			shift_q <= load_word;
		else if (state == ST_SHIFT)
			shift_q <= shift_q << 8;
	end

	assign crc_out = rev_out ? reflect_width(crc_q & width_mask, width) : (crc_q & width_mask);
	assign read_wait = deq.valid || (state != ST_IDLE);
	assign reset_pending = (state == ST_RELOAD);

	a_pop_valid: assert property (@(posedge HCLK) disable iff (!HRESETn)
		deq.pop |-> deq.valid);

endmodule

// File: logic/crc_regs.sv
`timescale 1ns/1ps

module crc_regs
(
	input logic HCLK,
	input logic HRESETn,
	input crc_pkg::word_t bus_wr,
	input logic crc_init_en,
	input logic crc_poly_en,
	input logic crc_idr_en,
	output crc_pkg::word_t crc_init_out,
	output crc_pkg::word_t crc_poly_out,
	output crc_pkg::idr_t crc_idr_out
);
	import crc_pkg::*;

	word_t init_q;
	word_t poly_q;
	idr_t idr_q;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_q <= INIT_RESET;
			poly_q <= POLY_RESET;
			idr_q <= '0;
		end
		else
		begin
			if (crc_init_en)
				init_q <= bus_wr;
			if (crc_poly_en)
				poly_q <= bus_wr; // used masked to the current width
			if (crc_idr_en)
				idr_q <= bus_wr[7:0];
		end
	end

	assign crc_init_out = init_q;
	assign crc_poly_out = poly_q;
	assign crc_idr_out = idr_q;

endmodule

// File: logic/crc_unit.sv
`timescale 1ns/1ps

module crc_unit
(
	input logic HCLK,
	input logic HRESETn,
	input logic HSElx,
	input logic [31:0] HADDR,
	input logic [1:0] HTRANS,
	input logic HWRITE,
	input logic [2:0] HSIZE,
	input logic HREADY,
	input crc_pkg::word_t HWDATA,
	output crc_pkg::word_t HRDATA,
	output logic HREADYOUT,
	output logic HRESP
);
	import crc_pkg::*;

	word_t bus_wr;
	xfer_size_t bus_size;
	logic buffer_write_en;
	logic crc_init_en;
	logic crc_poly_en;
	logic crc_idr_en;
	logic reset_chain;
	poly_size_t poly_size;
	rev_in_t rev_in;
	logic rev_out;
	logic buffer_full;
	logic read_wait;
	logic reset_pending;
	word_t crc_out;
	word_t crc_init_out;
	word_t crc_poly_out;
	idr_t crc_idr_out;

	crc_buf_if deq_if ();

	crc_host_if u_host (
		.HCLK(HCLK),
		.HRESETn(HRESETn),
		.HSEL(HSElx),
		.HADDR(HADDR),
		.HTRANS(htrans_t'(HTRANS)),
		.HWRITE(HWRITE),
		.HSIZE(HSIZE),
		.HREADY(HREADY),
		.HWDATA(HWDATA),
		.HRDATA(HRDATA),
		.HREADYOUT(HREADYOUT),
		.HRESP(HRESP),
		.bus_wr(bus_wr),
		.bus_size(bus_size),
		.buffer_write_en(buffer_write_en),
		.crc_init_en(crc_init_en),
		.crc_poly_en(crc_poly_en),
		.crc_idr_en(crc_idr_en),
		.reset_chain(reset_chain),
		.poly_size(poly_size),
		.rev_in(rev_in),
		.rev_out(rev_out),
		.buffer_full(buffer_full),
		.read_wait(read_wait),
		.reset_pending(reset_pending),
		.crc_out(crc_out),
		.crc_init_out(crc_init_out),
		.crc_poly_out(crc_poly_out),
		.crc_idr_out(crc_idr_out)
	);

	crc_data_buffer u_buf (
		.HCLK(HCLK),
		.HRESETn(HRESETn),
		.push(buffer_write_en),
		.push_word(bus_wr),
		.push_size(bus_size),
		.flush(reset_chain),
		.full(buffer_full),
		.deq(deq_if.buffer)
	);

	crc_engine u_engine (
		.HCLK(HCLK),
		.HRESETn(HRESETn),
		.deq(deq_if.engine),
		.reset_chain(reset_chain),
		.poly_size(poly_size),
		.rev_in(rev_in),
		.rev_out(rev_out),
		.init_value(crc_init_out),
		.poly(crc_poly_out),
		.crc_out(crc_out),
		.read_wait(read_wait),
		.reset_pending(reset_pending)
	);

	crc_regs u_regs (
		.HCLK(HCLK),
		.HRESETn(HRESETn),
		.bus_wr(bus_wr),
		.crc_init_en(crc_init_en),
		.crc_poly_en(crc_poly_en),
		.crc_idr_en(crc_idr_en),
		.crc_init_out(crc_init_out),
		.crc_poly_out(crc_poly_out),
		.crc_idr_out(crc_idr_out)
	);

endmodule

// File: sim/crc_checker.sv
`timescale 1ns/1ps

module crc_checker
(
	input logic HCLK,
	input logic HRESETn,
	input logic HSElx,
	input logic [31:0] HADDR,
	input logic [1:0] HTRANS,
	input logic HWRITE,
	input logic [2:0] HSIZE,
	input logic HREADY,
	input logic [31:0] HWDATA,
	input logic [31:0] HRDATA,
	input logic HREADYOUT,
	input logic HRESP,
	output int error_count,
	output int check_count
);
	logic [31:0] m_crc;
	logic [31:0] m_init;
	logic [31:0] m_pol;
	logic [7:0] m_idr;
	logic [1:0] m_psize;
	logic [1:0] m_rev_in;
	logic m_rev_out;
	logic dp_valid; // a transfer is in its data phase
	logic dp_write;
	logic [2:0] dp_word;
	logic [1:0] dp_size;

	function automatic int poly_bits(input logic [1:0] code);
		case (code)
			2'd0: return 32;
			2'd1: return 16;
			2'd2: return 8;
			default: return 7;
		endcase
	endfunction

	function automatic logic [31:0] low_mask(input int n);
		return (n == 32) ? 32'hFFFF_FFFF : ((32'h1 << n) - 32'h1);
	endfunction

	// feeds the low 8, 16 or 32 bits of d into the register, msb first
	function automatic logic [31:0] crc_feed(input logic [31:0] crc, input logic [31:0] d,
		input logic [1:0] size);
		int n;
		int nbits;
		int grp;
		logic [31:0] din;
		logic [31:0] c;
		logic fb;
		n = poly_bits(m_psize);
		nbits = 8 << size;
		grp = (m_rev_in == 2'd0) ? 1 : (4 << m_rev_in);
		if (grp > nbits)
			grp = nbits; // reversal stays inside the transfer
		for (int i = 0; i < 32; i++)
			din[i] = d[(i / grp) * grp + grp - 1 - (i % grp)];
		c = crc & low_mask(n);
		for (int b = nbits - 1; b >= 0; b--)
		begin
			fb = c[n - 1] ^ din[b];
			c = (c << 1) & low_mask(n);
			if (fb)
				c = c ^ (m_pol & low_mask(n));
		end
		return c;
	endfunction

	function automatic logic [31:0] read_model(input logic [2:0] word);
		logic [31:0] v;
		logic [31:0] r;
		int n;
		n = poly_bits(m_psize);
		case (word)
			3'd0:
			begin
				v = m_crc & low_mask(n);
				if (m_rev_out)
				begin
					r = '0;
					for (int i = 0; i < n; i++)
						r[i] = v[n - 1 - i];
					v = r;
				end
			end
			3'd1: v = {24'h0, m_idr};
			3'd2: v = {24'h0, m_rev_out, m_rev_in, m_psize, 3'b000};
			3'd4: v = m_init;
			3'd5: v = m_pol;
			default: v = '0;
		endcase
		return v;
	endfunction

	// only a DR access or an INIT write may hold the bus
	function automatic logic stall_allowed();
		return dp_valid && ((dp_word == 3'd0) || (dp_write && (dp_word == 3'd4)));
	endfunction

	task automatic finish_phase();
		logic [31:0] expect_val;
		check_count++;
		if (HRESP !== 1'b0)
		begin
			error_count++;
			$display("error: HRESP expected %0h got %0h", 1'b0, HRESP);
		end
		if (dp_write)
		begin
			case (dp_word)
				3'd0: m_crc = crc_feed(m_crc, HWDATA, dp_size);
				3'd1: m_idr = HWDATA[7:0];
				3'd2:
				begin
					m_psize = HWDATA[4:3];
					m_rev_in = HWDATA[6:5];
					m_rev_out = HWDATA[7];
					if (HWDATA[0])
						m_crc = m_init; // pending data is dropped
				end
				3'd4: m_init = HWDATA;
				3'd5: m_pol = HWDATA;
				default: ;
			endcase
		end
		else
		begin
			expect_val = read_model(dp_word);
			if (HRDATA !== expect_val)
			begin
				error_count++;
				$display("error: HRDATA word %0d expected %08h got %08h", dp_word, expect_val,
					HRDATA);
			end
		end
	endtask

	initial
	begin
		error_count = 0;
		check_count = 0;
	end

	always @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			m_crc = 32'hFFFF_FFFF;
			m_init = 32'hFFFF_FFFF;
			m_pol = 32'h04C1_1DB7;
			m_idr = '0;
			m_psize = '0;
			m_rev_in = '0;
			m_rev_out = 1'b0;
			dp_valid = 1'b0;
		end
		else
		begin
			if (HREADYOUT !== 1'b1 && !stall_allowed())
			begin
				error_count++;
				$display("error: HREADYOUT expected %0h got %0h", 1'b1, HREADYOUT);
			end
			if (HREADYOUT)
			begin
				if (dp_valid)
					finish_phase();
				dp_valid = HSElx && HREADY && (HTRANS == 2'b10);
				dp_write = HWRITE;
				dp_word = HADDR[4:2];
				dp_size = HSIZE[1:0];
			end
		end
	end

endmodule

// File: sim/crc_tb.sv
`timescale 1ns/1ps

module crc_tb;
	import crc_pkg::*;

	localparam int NUM_TRANS = 400;
	localparam int CYCLE_LIMIT = NUM_TRANS * 8 * 3; // up to 8 cycles per transaction, 3x margin

	logic HCLK;
	logic HRESETn;
	logic HSElx;
	logic [31:0] HADDR;
	logic [1:0] HTRANS;
	logic HWRITE;
	logic [2:0] HSIZE;
	logic HREADY;
	logic [31:0] HWDATA;
	logic [31:0] HRDATA;
	logic HREADYOUT;
	logic HRESP;
	int seed;
	int cycles;
	int error_count;
	int check_count;

	assign HREADY = HREADYOUT; // only slave on the bus

	crc_unit u_dut (
		.HCLK(HCLK),
		.HRESETn(HRESETn),
		.HSElx(HSElx),
		.HADDR(HADDR),
		.HTRANS(HTRANS),
		.HWRITE(HWRITE),
		.HSIZE(HSIZE),
		.HREADY(HREADY),
		.HWDATA(HWDATA),
		.HRDATA(HRDATA),
		.HREADYOUT(HREADYOUT),
		.HRESP(HRESP)
	);

	crc_checker u_chk (
		.HCLK(HCLK),
		.HRESETn(HRESETn),
		.HSElx(HSElx),
		.HADDR(HADDR),
		.HTRANS(HTRANS),
		.HWRITE(HWRITE),
		.HSIZE(HSIZE),
		.HREADY(HREADY),
		.HWDATA(HWDATA),
		.HRDATA(HRDATA),
		.HREADYOUT(HREADYOUT),
		.HRESP(HRESP),
		.error_count(error_count),
		.check_count(check_count)
	);

	initial
	begin
		HCLK = 1'b0;
		forever
			#10 HCLK = ~HCLK;
	end

	always @(posedge HCLK)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: the bus did not finish within %0d cycles", CYCLE_LIMIT);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	// one NONSEQ transfer; returns right after the address phase is accepted
	task automatic bus_xfer(input logic write, input logic [2:0] offset, input logic [2:0] size,
		input logic [31:0] data, input logic idle_after);
		HSElx <= 1'b1;
		HTRANS <= 2'b10;
		HADDR <= 32'h4002_3000 | {27'h0, offset, 2'b00};
		HWRITE <= write;
		HSIZE <= size;
		@(posedge HCLK);
		while (!HREADYOUT)
			@(posedge HCLK);
		HWDATA <= data; // held until the data phase ends
		if (idle_after)
		begin
			HSElx <= 1'b0;
			HTRANS <= 2'b00;
			@(posedge HCLK);
		end
	endtask

	task automatic random_op();
		int kind;
		int burst;
		logic idle_after;
		logic [31:0] value;
		logic [2:0] offset;
		kind = rand_below(100);
		idle_after = rand_below(2);
		value = rand_word();
		if (kind < 35)
			bus_xfer(1'b1, ADDR_DR, 3'(rand_below(3)), value, idle_after);
		else if (kind < 55)
			bus_xfer(1'b0, ADDR_DR, 3'd2, value, idle_after);
		else if (kind < 63)
		begin
			burst = 3 + rand_below(4); // enough to fill the buffer and stall
			repeat (burst)
				bus_xfer(1'b1, ADDR_DR, 3'(rand_below(3)), rand_word(), 1'b0);
			bus_xfer(1'b0, ADDR_DR, 3'd2, value, idle_after);
		end
		else if (kind < 80)
		begin
			// a DR read first lets the engine drain before the settings move
			if (kind < 73 && !value[0])
				bus_xfer(1'b0, ADDR_DR, 3'd2, value, 1'b0);
			else if (kind >= 73)
				bus_xfer(1'b0, ADDR_DR, 3'd2, value, 1'b0);
			bus_xfer(1'b1, (kind < 73) ? ADDR_CR : ADDR_POL, 3'd2, value, idle_after);
		end
		else if (kind < 86)
			bus_xfer(1'b1, ADDR_INIT, 3'd2, value, idle_after);
		else if (kind < 90)
			bus_xfer(1'b1, ADDR_IDR, 3'd2, value, idle_after);
		else if (kind < 93)
		begin
			offset = (rand_below(3) == 0) ? 3'd3 : ((rand_below(2) == 0) ? 3'd6 : 3'd7);
			bus_xfer(1'b1, offset, 3'd2, value, idle_after);
		end
		else
			bus_xfer(1'b0, 3'(1 + rand_below(7)), 3'd2, value, idle_after);
	endtask

	initial
	begin
		seed = 95051;
		cycles = 0;
		HRESETn = 1'b0;
		HSElx = 1'b0;
		HADDR = '0;
		HTRANS = 2'b00;
		HWRITE = 1'b0;
		HSIZE = 3'd2;
		HWDATA = '0;
		repeat (5) @(posedge HCLK);
		HRESETn <= 1'b1;
		@(posedge HCLK);
		bus_xfer(1'b0, ADDR_POL, 3'd2, '0, 1'b1);
		bus_xfer(1'b0, ADDR_INIT, 3'd2, '0, 1'b1);
		bus_xfer(1'b0, ADDR_IDR, 3'd2, '0, 1'b1);
		bus_xfer(1'b0, ADDR_CR, 3'd2, '0, 1'b1);
		bus_xfer(1'b0, ADDR_DR, 3'd2, '0, 1'b1);
		for (int n = 0; n < NUM_TRANS; n++)
			random_op();
		bus_xfer(1'b0, ADDR_DR, 3'd2, '0, 1'b1);
		@(posedge HCLK);
		while (!HREADYOUT)
			@(posedge HCLK);
		@(negedge HCLK);
		$display("checks: %0d  errors: %0d  cycles: %0d", check_count, error_count, cycles);
		if (error_count == 0 && check_count > 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: vlog.f
logic/crc_pkg.sv
logic/crc_buf_if.sv
logic/crc_host_if.sv
logic/crc_data_buffer.sv
logic/crc_engine.sv
logic/crc_regs.sv
logic/crc_unit.sv
sim/crc_checker.sv
sim/crc_tb.sv

// File: Bender.yml
package:
  name: crc_unit

sources:
  - files:
      - logic/crc_pkg.sv
      - logic/crc_buf_if.sv
      - logic/crc_host_if.sv
      - logic/crc_data_buffer.sv
      - logic/crc_engine.sv
      - logic/crc_regs.sv
      - logic/crc_unit.sv
  - target: simulation
    files:
      - sim/crc_checker.sv
      - sim/crc_tb.sv
